/* src/archPkg.sv */
// Core-wide widths and basic types for the out-of-order datapath.
// Every RTL file refers to these by scoped name, archPkg::word_t and so on.

package archPkg;

  // ------------------------------------------------
  // Widths
  // ------------------------------------------------
  localparam int XLEN     = 32;
  localparam int TAG_BITS = 3;  // Eight reorder-buffer slots

  // ------------------------------------------------
  // Types
  // ------------------------------------------------

  // One data value or one instruction address
  typedef logic [XLEN-1:0] word_t;

  // Names a reorder-buffer slot, also the tag broadcast on the data bus
  typedef logic [TAG_BITS-1:0] robTag_t;

endpackage

/* src/branchPkg.sv */
// Branch-side encodings: the control word that dispatch attaches to a branch,
// its condition and kind codes, and the result that resolution hands back
// to the reorder buffer.

package branchPkg;

  // ------------------------------------------------
  // Encodings
  // ------------------------------------------------
  typedef enum logic [1:0] {
    KIND_COND = 2'b00,
    KIND_JUMP = 2'b01
  } branchKind_e;

  typedef enum logic [2:0] {
    COND_EQ  = 3'd0,
    COND_NE  = 3'd1,
    COND_LT  = 3'd2,  // Signed compare
    COND_GE  = 3'd3,
    COND_LTU = 3'd4,  // Unsigned compare
    COND_GEU = 3'd5
  } branchCond_e;

  // ------------------------------------------------
  // Control word, one byte read two ways
  // ------------------------------------------------
  typedef struct packed {
    branchKind_e kind;
    branchCond_e cond;
    logic [2:0]  spare;
  } branchCondCtrl_t;

  typedef struct packed {
    branchKind_e kind;
    logic        link;      // Write pc + 4 to the destination
    logic        indirect;  // Target comes from src1
    logic [3:0]  spare;
  } branchJumpCtrl_t;

  // The kind sits in the top two bits of both views
  typedef union packed {
    branchCondCtrl_t cond;
    branchJumpCtrl_t jump;
  } branchCtrl_u;

  typedef struct packed {
    archPkg::robTag_t robTag;
    logic             taken;
    logic             mispredict;
    archPkg::word_t   nextPc;
    archPkg::word_t   linkValue;
  } branchResult_t;

endpackage

/* src/rsDispatchIf.sv */
// One dispatched branch on its way from the top-level ports into the
// reservation station. The write strobes are one-hot across the slots and the
// remaining fields are shared by all slots.

interface rsDispatchIf #(
  parameter int ENTRIES = 2
);
  logic [ENTRIES-1:0]   writeRequests;
  branchPkg::branchCtrl_u ctrl;
  archPkg::robTag_t     robTag;
  archPkg::robTag_t     srcTag1;
  archPkg::robTag_t     srcTag2;
  logic                 srcReady1;
  logic                 srcReady2;
  archPkg::word_t       srcValue1;
  archPkg::word_t       srcValue2;
  archPkg::word_t       pc;
  archPkg::word_t       offset;
  archPkg::word_t       predictedPc;

  modport top (
    output writeRequests, ctrl, robTag, srcTag1, srcTag2, srcReady1, srcReady2,
    output srcValue1, srcValue2, pc, offset, predictedPc
  );

  modport entry (
    input writeRequests, ctrl, robTag, srcTag1, srcTag2, srcReady1, srcReady2,
    input srcValue1, srcValue2, pc, offset, predictedPc
  );
endinterface

/* src/branchIssueIf.sv */
// Issue register contents passed from the station to the resolution stage.
// valid is a single-cycle pulse per issued branch.

interface branchIssueIf;
  logic                   valid;
  branchPkg::branchCtrl_u ctrl;
  archPkg::robTag_t       robTag;
  archPkg::word_t         src1;
  archPkg::word_t         src2;
  archPkg::word_t         pc;
  archPkg::word_t         offset;
  archPkg::word_t         predictedPc;

  modport station (
    output valid, ctrl, robTag, src1, src2, pc, offset, predictedPc
  );

  modport resolve (
    input valid, ctrl, robTag, src1, src2, pc, offset, predictedPc
  );
endinterface

/* src/branchRsEntry.sv */
// One reservation-station slot. Holds a dispatched branch until both
// operands are known, snooping the common data bus for the missing ones.
// Raises selectReq once complete and frees itself when granted or cleared.

module branchRsEntry (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   clear,
  rsDispatchIf.entry             dispatch,
  input  logic                   writeReq,
  input  logic                   selected,
  input  logic                   cdbValid,
  input  archPkg::robTag_t       cdbTag,
  input  archPkg::word_t         cdbValue,
  output logic                   busy,
  output logic                   selectReq,
  output branchPkg::branchCtrl_u ctrl,
  output archPkg::robTag_t       robTag,
  output archPkg::word_t         src1,
  output archPkg::word_t         src2,
  output archPkg::word_t         pc,
  output archPkg::word_t         offset,
  output archPkg::word_t         predictedPc
);

  archPkg::robTag_t dispTag [2];
  archPkg::word_t   dispValue [2];
  logic [1:0]       dispReady;
  logic [1:0]       dispHit;  // Bus supplies the operand in the dispatch cycle
  logic [1:0]       waitHit;  // Bus supplies an operand already waiting

  archPkg::robTag_t waitTag [2];
  archPkg::word_t   operand [2];
  logic [1:0]       ready;

  assign dispTag[0]   = dispatch.srcTag1;
  assign dispTag[1]   = dispatch.srcTag2;
  assign dispValue[0] = dispatch.srcValue1;
  assign dispValue[1] = dispatch.srcValue2;
  assign dispReady    = {dispatch.srcReady2, dispatch.srcReady1};

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      dispHit[i] = !dispReady[i] && cdbValid && (cdbTag == dispTag[i]);
      waitHit[i] = busy && !ready[i] && cdbValid && (cdbTag == waitTag[i]);
    end
  end

  // ------------------------------------------------
  // Slot state
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      busy <= 1'b0;
    end else if (writeReq) begin
      busy <= 1'b1;
    end else if (selected) begin
      busy <= 1'b0;  // Leaves as the issue register loads
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (rst) begin
        ready[i] <= 1'b0;
      end else if (writeReq) begin
        ready[i] <= dispReady[i] || dispHit[i];
      end else if (waitHit[i]) begin
        ready[i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (writeReq) begin
        waitTag[i] <= dispTag[i];
        operand[i] <= dispHit[i] ? cdbValue : dispValue[i];
      end else if (waitHit[i]) begin
        operand[i] <= cdbValue;
      end
    end
    if (writeReq) begin
      ctrl        <= dispatch.ctrl;
      robTag      <= dispatch.robTag;
      pc          <= dispatch.pc;
      offset      <= dispatch.offset;
      predictedPc <= dispatch.predictedPc;
    end
  end

  assign selectReq = busy && (&ready);
  assign src1      = operand[0];
  assign src2      = operand[1];

endmodule

/* src/branchIssueSelect.sv */
// Picks one ready slot per cycle with a rotating priority and loads its
// fields into the issue register. The pointer moves past each winner so
// that no slot is starved.

module branchIssueSelect #(
  parameter int ENTRIES = 2
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 clear,
  input  logic [ENTRIES-1:0]                   selectReqs,
  input  branchPkg::branchCtrl_u [ENTRIES-1:0] ctrls,
  input  archPkg::robTag_t [ENTRIES-1:0]       robTags,
  input  archPkg::word_t [ENTRIES-1:0]         src1s,
  input  archPkg::word_t [ENTRIES-1:0]         src2s,
  input  archPkg::word_t [ENTRIES-1:0]         pcs,
  input  archPkg::word_t [ENTRIES-1:0]         offsets,
  input  archPkg::word_t [ENTRIES-1:0]         predictedPcs,
  output logic [ENTRIES-1:0]                   grants,
  branchIssueIf.station                        issue
);

  localparam int PTR_BITS = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  logic [PTR_BITS-1:0] pointer;  // Slot with the highest priority this cycle
  logic [PTR_BITS-1:0] winner;
  logic                anyGrant;

  // ------------------------------------------------
  // Grant, scanning upward from the pointer
  // ------------------------------------------------
  always_comb begin
    int idx;
    grants   = '0;
    winner   = '0;
    anyGrant = 1'b0;
    for (int k = 0; k < ENTRIES; k++) begin
      idx = int'(pointer) + k;
      if (idx >= ENTRIES) idx = idx - ENTRIES;
      if (!anyGrant && selectReqs[idx]) begin
        anyGrant = 1'b1;
        winner   = PTR_BITS'(idx);
      end
    end
    if (anyGrant) grants[winner] = 1'b1;
  end

  // ------------------------------------------------
  // Pointer and issue register
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      pointer <= '0;
    end else if (anyGrant) begin
      pointer <= (winner == PTR_BITS'(ENTRIES - 1)) ? '0 : winner + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) issue.valid <= 1'b0;
    else              issue.valid <= anyGrant;
  end

  always_ff @(posedge clk) begin
    if (anyGrant) begin
      issue.ctrl        <= ctrls[winner];
      issue.robTag      <= robTags[winner];
      issue.src1        <= src1s[winner];
      issue.src2        <= src2s[winner];
      issue.pc          <= pcs[winner];
      issue.offset      <= offsets[winner];
      issue.predictedPc <= predictedPcs[winner];
    end
  end

endmodule

/* src/branchRs.sv */
// Branch reservation station. Builds ENTRIES slots, collects their requests
// and fields for the issue select, and routes each grant back to its slot.

module branchRs #(
  parameter int ENTRIES = 2
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               clear,
  rsDispatchIf.entry         dispatch,
  input  logic               cdbValid,
  input  archPkg::robTag_t   cdbTag,
  input  archPkg::word_t     cdbValue,
  output logic [ENTRIES-1:0] busy,
  branchIssueIf.station      issue
);

  logic [ENTRIES-1:0]                   selectReqs;
  logic [ENTRIES-1:0]                   grants;
  branchPkg::branchCtrl_u [ENTRIES-1:0] ctrls;
  archPkg::robTag_t [ENTRIES-1:0]       robTags;
  archPkg::word_t [ENTRIES-1:0]         src1s;
  archPkg::word_t [ENTRIES-1:0]         src2s;
  archPkg::word_t [ENTRIES-1:0]         pcs;
  archPkg::word_t [ENTRIES-1:0]         offsets;
  archPkg::word_t [ENTRIES-1:0]         predictedPcs;

  for (genvar i = 0; i < ENTRIES; i++) begin : gSlot
    branchRsEntry slot (
      .clk, .rst, .clear, .dispatch,
      .writeReq    (dispatch.writeRequests[i]),
      .selected    (grants[i]),
      .cdbValid, .cdbTag, .cdbValue,
      .busy        (busy[i]),
      .selectReq   (selectReqs[i]),
      .ctrl        (ctrls[i]),
      .robTag      (robTags[i]),
      .src1        (src1s[i]),
      .src2        (src2s[i]),
      .pc          (pcs[i]),
      .offset      (offsets[i]),
      .predictedPc (predictedPcs[i])
    );
  end

  branchIssueSelect #(.ENTRIES(ENTRIES)) select (
    .clk, .rst, .clear, .selectReqs, .ctrls, .robTags, .src1s, .src2s,
    .pcs, .offsets, .predictedPcs, .grants, .issue
  );

endmodule

/* src/branchResolve.sv */
// Resolution stage. Evaluates the issued branch in one cycle and registers
// the outcome: taken, the actual next PC, the link value and whether fetch
// guessed wrong.

module branchResolve (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clear,
  branchIssueIf.resolve            issue,
  output logic                     resultValid,
  output branchPkg::branchResult_t result
);

  branchPkg::branchResult_t nextResult;
  archPkg::word_t           seqPc;
  archPkg::word_t           relTarget;
  archPkg::word_t           indTarget;
  logic                     condTrue;

  assign seqPc     = issue.pc + archPkg::word_t'(4);
  assign relTarget = issue.pc + issue.offset;
  assign indTarget = (issue.src1 + issue.offset) & ~archPkg::word_t'(1);

  always_comb begin
    unique case (issue.ctrl.cond.cond)
      branchPkg::COND_EQ:  condTrue = issue.src1 == issue.src2;
      branchPkg::COND_NE:  condTrue = issue.src1 != issue.src2;
      branchPkg::COND_LT:  condTrue = $signed(issue.src1) <  $signed(issue.src2);
      branchPkg::COND_GE:  condTrue = $signed(issue.src1) >= $signed(issue.src2);
      branchPkg::COND_LTU: condTrue = issue.src1 <  issue.src2;
      branchPkg::COND_GEU: condTrue = issue.src1 >= issue.src2;
      default:             condTrue = 1'b0;
    endcase
  end

  // ------------------------------------------------
  // Next PC and link value by kind
  // ------------------------------------------------
  always_comb begin
    nextResult.robTag = issue.robTag;
    if (issue.ctrl.jump.kind == branchPkg::KIND_JUMP) begin
      nextResult.taken     = 1'b1;
      nextResult.nextPc    = issue.ctrl.jump.indirect ? indTarget : relTarget;
      nextResult.linkValue = issue.ctrl.jump.link ? seqPc : '0;
    end else begin
      nextResult.taken     = condTrue;
      nextResult.nextPc    = condTrue ? relTarget : seqPc;
      nextResult.linkValue = '0;
    end
    nextResult.mispredict = nextResult.nextPc != issue.predictedPc;
  end

  always_ff @(posedge clk) begin
    if (rst || clear) resultValid <= 1'b0;
    else              resultValid <= issue.valid;
  end

  always_ff @(posedge clk) begin
    if (issue.valid) result <= nextResult;
  end

endmodule

/* src/branchUnit.sv */
// Top level of the branch subsystem. Dispatch, the common data bus and the
// result come and go on plain ports; inside, the station feeds the
// resolution stage. A result follows dispatch by two edges when both
// operands are ready at dispatch.

module branchUnit #(
  parameter int ENTRIES = 2
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clear,
  input  logic [ENTRIES-1:0]       writeRequests,
  input  branchPkg::branchCtrl_u   ctrl,
  input  archPkg::robTag_t         robTag,
  input  archPkg::robTag_t         srcTag1,
  input  archPkg::robTag_t         srcTag2,
  input  logic                     srcReady1,
  input  logic                     srcReady2,
  input  archPkg::word_t           srcValue1,
  input  archPkg::word_t           srcValue2,
  input  archPkg::word_t           pc,
  input  archPkg::word_t           offset,
  input  archPkg::word_t           predictedPc,
  input  logic                     cdbValid,
  input  archPkg::robTag_t         cdbTag,
  input  archPkg::word_t           cdbValue,
  output logic [ENTRIES-1:0]       busy,
  output logic                     resultValid,
  output branchPkg::branchResult_t result
);

  rsDispatchIf #(.ENTRIES(ENTRIES)) dispatchBus ();
  branchIssueIf                     issueBus ();

  assign dispatchBus.writeRequests = writeRequests;
  assign dispatchBus.ctrl          = ctrl;
  assign dispatchBus.robTag        = robTag;
  assign dispatchBus.srcTag1       = srcTag1;
  assign dispatchBus.srcTag2       = srcTag2;
  assign dispatchBus.srcReady1     = srcReady1;
  assign dispatchBus.srcReady2     = srcReady2;
  assign dispatchBus.srcValue1     = srcValue1;
  assign dispatchBus.srcValue2     = srcValue2;
  assign dispatchBus.pc            = pc;
  assign dispatchBus.offset        = offset;
  assign dispatchBus.predictedPc   = predictedPc;

  branchRs #(.ENTRIES(ENTRIES)) station (
    .clk, .rst, .clear,
    .dispatch (dispatchBus),
    .cdbValid, .cdbTag, .cdbValue, .busy,
    .issue    (issueBus)
  );

  branchResolve resolve (
    .clk, .rst, .clear,
    .issue (issueBus),
    .resultValid, .result
  );

endmodule

/* test/branchUnit_assert.sv */
// Protocol checks on the branch unit ports, bound into every branchUnit.

module branchUnitAssert #(
  parameter int ENTRIES = 2
) (
  input logic clk, rst, clear, resultValid,
  input logic [ENTRIES-1:0] writeRequests,
  input logic [ENTRIES-1:0] busy
);
  timeunit 1ns;
  timeprecision 100ps;

  noWriteToBusy: assert property (@(posedge clk) disable iff (rst)
    (writeRequests & busy) == '0) else $error("dispatch wrote a busy entry");
  oneWriteAtMost: assert property (@(posedge clk) disable iff (rst)
    $onehot0(writeRequests)) else $error("more than one write strobe");
  quietAfterClear: assert property (@(posedge clk) disable iff (rst)
    clear |=> !resultValid) else $error("result right after clear");
  idleAfterReset: assert property (@(posedge clk)
    rst |=> busy == '0) else $error("entry busy after reset");
endmodule

bind branchUnit branchUnitAssert #(.ENTRIES(ENTRIES)) assertions (
  .clk, .rst, .clear, .resultValid, .writeRequests, .busy
);

/* test/branchChecker.sv */
// Scoreboard for the branch unit. Tracks every dispatched branch by its tag,
// fills waiting operands from the data bus, and compares each result with
// the reference model. The testbench calls endTest after each test.

module branchChecker #(
  parameter int ENTRIES = 2
) (
  input  logic clk, rst, clear,
  input  logic [ENTRIES-1:0] writeRequests,
  input  logic [7:0] ctrl,
  input  archPkg::robTag_t robTag, srcTag1, srcTag2, cdbTag,
  input  logic srcReady1, srcReady2, cdbValid,
  input  archPkg::word_t srcValue1, srcValue2, pc, offset, predictedPc, cdbValue,
  input  logic [ENTRIES-1:0] busy,
  input  logic resultValid,
  input  branchPkg::branchResult_t result,
  output int pending
);
  timeunit 1ns;
  timeprecision 100ps;

  logic pend [8], rdy1 [8], rdy2 [8], quick [8];
  logic [7:0] ctl [8];
  archPkg::robTag_t tag1 [8], tag2 [8];
  archPkg::word_t val1 [8], val2 [8], pcs [8], offs [8], preds [8];
  int dispCycle [8];
  int cycle = 0;
  int testErrors = 0, testResults = 0, totalErrors = 0, totalResults = 0;

  // Reference model, written from the branch rules
  function automatic branchPkg::branchResult_t expectResult(logic [7:0] c,
      archPkg::word_t a, archPkg::word_t b, archPkg::word_t p, archPkg::word_t o,
      archPkg::word_t pred, archPkg::robTag_t t);
    branchPkg::branchResult_t r;
    r.robTag = t;
    r.linkValue = '0;
    if (c[7:6] == 2'b01) begin
      r.taken = 1'b1;
      r.nextPc = c[4] ? ((a + o) & 32'hffff_fffe) : p + o;
      r.linkValue = c[5] ? p + 4 : '0;
    end else begin
      case (c[5:3])
        3'd0: r.taken = a == b;
        3'd1: r.taken = a != b;
        3'd2: r.taken = $signed(a) < $signed(b);
        3'd3: r.taken = $signed(a) >= $signed(b);
        3'd4: r.taken = a < b;
        3'd5: r.taken = a >= b;
        default: r.taken = 1'b0;
      endcase
      r.nextPc = r.taken ? p + o : p + 4;
    end
    r.mispredict = r.nextPc != pred;
    return r;
  endfunction

  task automatic checkField(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("Error: %s expected %h got %h", name, exp, act);
      testErrors++;
    end
  endtask

  always_comb begin
    pending = 0;
    for (int t = 0; t < 8; t++) pending += int'(pend[t]);
  end

  // --------------------------------------------------
  // Scoreboard
  // --------------------------------------------------
  always @(posedge clk) begin
    branchPkg::branchResult_t e;
    archPkg::robTag_t t;
    cycle++;
    if (resultValid && !rst) begin
      t = result.robTag;
      if (!pend[t] || !rdy1[t] || !rdy2[t]) begin
        $display("Result for tag %0d which has no complete pending branch", t);
        testErrors++;
      end else begin
        e = expectResult(ctl[t], val1[t], val2[t], pcs[t], offs[t], preds[t], t);
        checkField("taken", 32'(e.taken), 32'(result.taken));
        checkField("mispredict", 32'(e.mispredict), 32'(result.mispredict));
        checkField("nextPc", e.nextPc, result.nextPc);
        checkField("linkValue", e.linkValue, result.linkValue);
        // Sampled one edge after the result register loads
        if (quick[t] && cycle - dispCycle[t] != 3) begin
          $display("Result for tag %0d came %0d edges after dispatch instead of two",
                   t, cycle - dispCycle[t] - 1);
          testErrors++;
        end
        pend[t] = 1'b0;
        testResults++;
      end
    end
    if (rst || clear) begin
      for (int i = 0; i < 8; i++) pend[i] = 1'b0;
    end else begin
      for (int i = 0; i < 8; i++) begin
        if (pend[i] && cdbValid && !rdy1[i] && tag1[i] == cdbTag) {rdy1[i], val1[i]} = {1'b1, cdbValue};
        if (pend[i] && cdbValid && !rdy2[i] && tag2[i] == cdbTag) {rdy2[i], val2[i]} = {1'b1, cdbValue};
      end
      if (writeRequests != '0) begin
        t = robTag;
        pend[t] = 1'b1;
        {ctl[t], pcs[t], offs[t], preds[t], tag1[t], tag2[t]} =
            {ctrl, pc, offset, predictedPc, srcTag1, srcTag2};
        rdy1[t] = srcReady1 || (cdbValid && cdbTag == srcTag1);
        rdy2[t] = srcReady2 || (cdbValid && cdbTag == srcTag2);
        val1[t] = (!srcReady1 && rdy1[t]) ? cdbValue : srcValue1;
        val2[t] = (!srcReady2 && rdy2[t]) ? cdbValue : srcValue2;
        quick[t] = rdy1[t] && rdy2[t] && busy == '0;
        dispCycle[t] = cycle;
      end
    end
  end

  task automatic endTest(string name);
    for (int i = 0; i < 8; i++) begin
      if (pend[i]) begin
        $display("Tag %0d still has no result at the end of the test", i);
        testErrors++;
        pend[i] = 1'b0;
      end
    end
    $display("Test %s: %0d results, %0d errors", name, testResults, testErrors);
    totalErrors += testErrors;
    totalResults += testResults;
    testErrors = 0;
    testResults = 0;
  endtask

endmodule

/* test/tb_branchUnit.sv */
// Testbench top for the branch unit. Makes clock and reset, drives dispatch
// and data-bus traffic on falling edges, and leaves the comparing to the
// checker. Run through the Makefile or any simulator with filelist.f.

module tb_branchUnit;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ENTRIES = 2;
  localparam int TIMEOUT = 60;  // Cycles allowed for any single wait

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic clear = 1'b0;
  logic [ENTRIES-1:0] writeRequests = '0;
  branchPkg::branchCtrl_u ctrl = '0;
  archPkg::robTag_t robTag = '0, srcTag1 = '0, srcTag2 = '0, cdbTag = '0;
  logic srcReady1 = 1'b0, srcReady2 = 1'b0, cdbValid = 1'b0;
  archPkg::word_t srcValue1 = '0, srcValue2 = '0, pc = '0, offset = '0;
  archPkg::word_t predictedPc = '0, cdbValue = '0;
  logic [ENTRIES-1:0] busy;
  logic resultValid;
  branchPkg::branchResult_t result;
  int pending;
  int tbErrors = 0;
  logic timedOut = 1'b0;
  logic [31:0] lfsr = 32'h8a1b_0f76;
  archPkg::robTag_t nextTag = '0;

  always #4 clk = ~clk;

  branchUnit #(.ENTRIES(ENTRIES)) uut (.*);

  branchChecker #(.ENTRIES(ENTRIES)) chk (
    .clk, .rst, .clear, .writeRequests, .ctrl, .robTag, .srcTag1, .srcTag2,
    .srcReady1, .srcReady2, .srcValue1, .srcValue2, .pc, .offset, .predictedPc,
    .cdbValid, .cdbTag, .cdbValue, .busy, .resultValid, .result, .pending
  );

  // One LFSR step per bit taken
  function automatic logic [31:0] randBits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic archPkg::word_t randOffset();
    return archPkg::word_t'((signed'(randBits(12) << 1) <<< 19) >>> 19);
  endfunction

  task automatic failWait(string what);
    $display("Timeout while waiting for %s", what);
    tbErrors++;
    timedOut = 1'b1;
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic dispatchBranch(logic [7:0] c, logic r1, archPkg::robTag_t t1,
                                archPkg::word_t v1, logic r2, archPkg::robTag_t t2,
                                archPkg::word_t v2, archPkg::word_t pcV,
                                archPkg::word_t offV, archPkg::word_t pred,
                                logic busNow = 1'b0, archPkg::robTag_t busTag = '0,
                                archPkg::word_t busVal = '0);
    int slot;
    int n;
    slot = -1;
    n = 0;
    while (slot < 0 && !timedOut) begin
      @(negedge clk);
      for (int i = ENTRIES - 1; i >= 0; i--) if (!busy[i]) slot = i;
      if (slot < 0 && ++n > TIMEOUT) failWait("a free station entry");
    end
    if (timedOut) return;
    writeRequests = '0;
    writeRequests[slot] = 1'b1;
    ctrl = c;
    robTag = nextTag++;
    {srcReady1, srcTag1, srcValue1} = {r1, t1, v1};
    {srcReady2, srcTag2, srcValue2} = {r2, t2, v2};
    {pc, offset, predictedPc} = {pcV, offV, pred};
    {cdbValid, cdbTag, cdbValue} = {busNow, busTag, busVal};
    @(negedge clk);
    writeRequests = '0;
    cdbValid = 1'b0;
  endtask

  task automatic broadcast(archPkg::robTag_t t, archPkg::word_t v);
    @(negedge clk);
    {cdbValid, cdbTag, cdbValue} = {1'b1, t, v};
    @(negedge clk);
    cdbValid = 1'b0;
  endtask

  task automatic waitDrain(string what);
    int n;
    n = 0;
    while (!timedOut && (busy != '0 || pending != 0)) begin
      @(negedge clk);
      if (++n > TIMEOUT) failWait(what);
    end
    repeat (2) @(negedge clk);
  endtask

  initial begin
    archPkg::word_t a, b, p, o;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // Test 1: all six conditions with ready operands, one at a time
    for (int i = 0; i < 24; i++) begin
      a = randBits(32);
      b = (i / 6 == 0) ? a : (i / 6 == 1) ? (a ^ 32'h8000_0000) : randBits(32);
      p = randBits(30) << 2;
      o = randOffset();
      dispatchBranch({2'b00, 3'(i % 6), 3'b0}, 1'b1, '0, a, 1'b1, '0, b, p, o,
                     randBits(1) ? p + o : p + 4);
      waitDrain("a conditional branch");
    end
    chk.endTest("conditions");

    // Test 2: operands from the data bus, later and in the dispatch cycle
    dispatchBranch({2'b00, 3'd0, 3'b0}, 1'b0, 3'd5, 32'hdead, 1'b1, '0, 32'h77,
                   32'h1000, 32'h40, 32'h1040);
    broadcast(3'd5, 32'h77);
    dispatchBranch({2'b00, 3'd2, 3'b0}, 1'b0, 3'd6, 32'h1, 1'b0, 3'd4, 32'h0,
                   32'h2000, 32'h80, 32'h2004, 1'b1, 3'd6, 32'hffff_fff0);
    broadcast(3'd4, 32'h5);
    waitDrain("bus-fed operands");
    chk.endTest("bus operands");

    // Test 3: jumps, direct and indirect, with and without link
    for (int i = 0; i < 4; i++) begin
      a = randBits(32) | 32'h1;
      dispatchBranch({2'b01, 1'(i), 1'(i >> 1), 4'b0}, 1'b1, '0, a, 1'b1, '0, '0,
                     32'h3000 + 32'(i * 16), randOffset(), 32'h0);
      waitDrain("a jump");
    end
    chk.endTest("jumps");

    // Test 4: prediction equal to and different from the real next PC
    dispatchBranch({2'b00, 3'd0, 3'b0}, 1'b1, '0, 9, 1'b1, '0, 9, 32'h400, 32'h20, 32'h420);
    dispatchBranch({2'b00, 3'd0, 3'b0}, 1'b1, '0, 9, 1'b1, '0, 9, 32'h400, 32'h20, 32'h404);
    dispatchBranch({2'b00, 3'd1, 3'b0}, 1'b1, '0, 9, 1'b1, '0, 9, 32'h500, 32'h20, 32'h504);
    dispatchBranch({2'b01, 2'b00, 4'b0}, 1'b1, '0, 0, 1'b1, '0, 0, 32'h600, 32'h8, 32'h60c);
    waitDrain("predicted branches");
    chk.endTest("mispredict");

    // Test 5: both entries become ready in the same cycle
    for (int i = 0; i < 6; i++) begin
      a = randBits(32);
      dispatchBranch({2'b00, 3'd4, 3'b0}, 1'b0, 3'd3, 0, 1'b1, '0, randBits(32),
                     32'h800, 32'h10, 32'h804);
      dispatchBranch({2'b00, 3'd5, 3'b0}, 1'b1, '0, randBits(32), 1'b0, 3'd3, 0,
                     32'h900, 32'h10, 32'h910);
      broadcast(3'd3, a);
      waitDrain("both entries to drain");
    end
    chk.endTest("both ready");

    // Test 6: flush with entries waiting and in flight, then normal traffic
    dispatchBranch({2'b00, 3'd0, 3'b0}, 1'b0, 3'd7, 0, 1'b1, '0, 0, 32'ha00, 8, 0);
    dispatchBranch({2'b01, 2'b11, 4'b0}, 1'b1, '0, 32'h41, 1'b1, '0, 0, 32'hb00, 8, 0);
    clear = 1'b1;  // The jump is granted at this edge
    @(negedge clk);
    clear = 1'b0;
    dispatchBranch({2'b00, 3'd1, 3'b0}, 1'b1, '0, 3, 1'b1, '0, 4, 32'hd00, 8, 0);
    @(negedge clk);
    clear = 1'b1;  // Now the branch sits in the issue register
    @(negedge clk);
    clear = 1'b0;
    broadcast(3'd7, 32'h123);
    repeat (6) @(negedge clk);
    if (busy != '0) begin
      $display("Station entries still busy after clear");
      tbErrors++;
    end
    dispatchBranch({2'b00, 3'd1, 3'b0}, 1'b1, '0, 1, 1'b1, '0, 2, 32'hc00, 32'h40, 32'hc40);
    waitDrain("dispatch after clear");
    chk.endTest("clear");

    $display("Totals: %0d results, %0d errors", chk.totalResults, chk.totalErrors + tbErrors);
    if (chk.totalErrors + tbErrors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
src/archPkg.sv
src/branchPkg.sv
src/rsDispatchIf.sv
src/branchIssueIf.sv
src/branchRsEntry.sv
src/branchIssueSelect.sv
src/branchRs.sv
src/branchResolve.sv
src/branchUnit.sv
test/branchUnit_assert.sv
test/branchChecker.sv
test/tb_branchUnit.sv

/* Makefile */
TOP = tb_branchUnit

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
